// File: digital_clock_top.f
hdl/clock_pkg.sv
hdl/clock_ctrl_if.sv
hdl/switch_debounce.sv
hdl/mode_ctrl.sv
hdl/time_keeper.sv
hdl/alarm_keeper.sv
hdl/seg_display.sv
hdl/digital_clock_top.sv
tb/digital_clock_checker.sv
tb/tb_digital_clock.sv

// File: run_sim.sh
#!/bin/sh
# Build the digital clock testbench with Verilator and run it.
# The result is taken from the simulation log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_digital_clock -f digital_clock_top.f

sim_status=0
./obj_dir/Vtb_digital_clock +verilator+error+limit+100 > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q -F '*** PASSED ***' sim.log; then
	echo "Simulation passed (exit status $sim_status)"
	exit 0
fi
echo "Simulation failed (exit status $sim_status)"
exit 1

// File: tb/clock_testdata.txt
# command and arguments, one per line
# press <mode|pos|inc|alarm> <count> / expect_frame <hh> <mm> <ss>
# wait_frame <hh> <mm> <ss> <timeout frames> / expect_alarm <0|1> <timeout clocks>
expect_frame 0 0 0
expect_alarm 0 4
press mode 1
expect_frame 0 0 0
press inc 20
press pos 2
press inc 25
expect_frame 1 0 20
press mode 1
expect_frame 0 0 0
press inc 1
press pos 1
press inc 2
expect_frame 1 0 2
press mode 1
wait_frame 1 0 23 150
press mode 1
press inc 35
press pos 1
press inc 59
press pos 1
press inc 23
expect_frame 0 59 58
press mode 2
wait_frame 1 0 0 150
press alarm 1
expect_alarm 1 6000
press alarm 1
expect_alarm 0 4

// File: tb/tb_digital_clock.sv
// --------------------------------------------------
// Testbench for the digital clock
// Runs the commands in tb/clock_testdata.txt: presses
// switches, captures scanned display frames and checks
// them and the alarm flag against expected values
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_digital_clock
	import clock_pkg::*;
();

localparam int CLK_HALF      = 10;
localparam int RESET_CYCLES  = 8;
localparam int SCAN_TIMEOUT  = 2 * NUM_DIGITS * SCAN_DIV;
localparam int PRESS_TIMEOUT = 2 * SAMPLE_DIV + 4;

logic				clk;
logic				rst_n;
logic				sw_mode;
logic				sw_pos;
logic				sw_inc;
logic				sw_alarm;
logic	[SEG_W-1:0]		seg;
logic				seg_dp;
logic	[NUM_DIGITS-1:0]	seg_enb;
logic				alarm;

int				error_count;
int				timeout_count;
int				assert_count;
logic	[MODE_W-1:0]		exp_mode;
hms_seg_u			got_frame;
logic	[NUM_DIGITS-1:0]	got_dp;

digital_clock_top u_dut (
	.i_sw_mode	(sw_mode),
	.i_sw_pos	(sw_pos),
	.i_sw_inc	(sw_inc),
	.i_sw_alarm	(sw_alarm),
	.o_seg		(seg),
	.o_seg_dp	(seg_dp),
	.o_seg_enb	(seg_enb),
	.o_alarm	(alarm),
	.clk		(clk),
	.rst_n		(rst_n)
);

initial begin
	clk = 1'b0;
	forever begin
		#CLK_HALF clk = ~clk;
	end
end

// --------------------------------------------------
// Expected values
// --------------------------------------------------
// Standard digit patterns, segment a in the MSB
function automatic logic [SEG_W-1:0] digit_pattern(input int value);
	case (value)
		0:       return 7'b1111110;
		1:       return 7'b0110000;
		2:       return 7'b1101101;
		3:       return 7'b1111001;
		4:       return 7'b0110011;
		5:       return 7'b1011011;
		6:       return 7'b1011111;
		7:       return 7'b1110000;
		8:       return 7'b1111111;
		9:       return 7'b1110011;
		default: return 7'b0000000;
	endcase
endfunction

function automatic hms_seg_u frame_of(input int hh, input int mm, input int ss);
	hms_seg_u f;
	f.digit[0] = digit_pattern(ss % 10);
	f.digit[1] = digit_pattern(ss / 10);
	f.digit[2] = digit_pattern(mm % 10);
	f.digit[3] = digit_pattern(mm / 10);
	f.digit[4] = digit_pattern(hh % 10);
	f.digit[5] = digit_pattern(hh / 10);
	return f;
endfunction

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_pattern(input logic [SEG_W-1:0] got, input logic [SEG_W-1:0] exp,
		input string name);
	if (got !== exp) begin
		error_count = error_count + 1;
		$display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic check_frame(input hms_seg_u got, input hms_seg_u exp, input string name);
	if (got !== exp) begin
		error_count = error_count + 1;
		$display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
	end
endtask

task automatic check_bit(input logic got, input logic exp, input string name);
	if (got !== exp) begin
		error_count = error_count + 1;
		$display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
	end
endtask

task automatic check_enable(input logic [NUM_DIGITS-1:0] got,
		input logic [NUM_DIGITS-1:0] exp, input string name);
	if (got !== exp) begin
		error_count = error_count + 1;
		$display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
	end
endtask

// Decimal points carry the mode bits on digits 0 and 1
task automatic check_points();
	int k;
	logic [NUM_DIGITS-1:0] exp_dp;
	exp_dp    = '0;
	exp_dp[0] = exp_mode[0];
	exp_dp[1] = exp_mode[1];
	for (k = 0; k < NUM_DIGITS; k++) begin
		check_bit(got_dp[k], exp_dp[k], $sformatf("o_seg_dp[%0d]", k));
	end
endtask

// --------------------------------------------------
// Display capture
// --------------------------------------------------
task automatic capture_frame();
	int k;
	int waited;
	logic [NUM_DIGITS-1:0] target;
	for (k = 0; k < NUM_DIGITS; k++) begin
		target = ~(NUM_DIGITS'(1) << k);
		waited = 0;
		while (seg_enb !== target && waited < SCAN_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (seg_enb !== target) begin
			timeout_count = timeout_count + 1;
			$display("Timed out waiting for display digit %0d to be enabled", k);
			return;
		end
		got_frame.digit[k] = seg;
		got_dp[k]          = seg_dp;
	end
endtask

task automatic expect_frame(input int hh, input int mm, input int ss);
	capture_frame();
	check_frame(got_frame, frame_of(hh, mm, ss), "display frame");
	check_points();
endtask

task automatic wait_frame(input int hh, input int mm, input int ss, input int limit);
	int n;
	logic matched;
	n       = 0;
	matched = 1'b0;
	while (!matched && n < limit) begin
		capture_frame();
		matched = (got_frame === frame_of(hh, mm, ss));
		n++;
	end
	if (matched) begin
		check_points();
	end else begin
		timeout_count = timeout_count + 1;
		$display("Display never showed %02d:%02d:%02d within %0d frames", hh, mm, ss, limit);
	end
endtask

task automatic expect_alarm(input logic value, input int limit);
	int waited;
	waited = 0;
	while (alarm !== value && waited < limit) begin
		@(negedge clk);
		waited++;
	end
	check_bit(alarm, value, "o_alarm");
endtask

// --------------------------------------------------
// Switch presses
// --------------------------------------------------
task automatic set_switch(input string name, input logic level);
	case (name)
		"mode":  sw_mode  = level;
		"pos":   sw_pos   = level;
		"inc":   sw_inc   = level;
		"alarm": sw_alarm = level;
		default: ;
	endcase
endtask

function automatic logic press_seen(input string name);
	case (name)
		"mode":  return u_dut.u_mode_ctrl.press_mode;
		"pos":   return u_dut.u_mode_ctrl.press_pos;
		"inc":   return u_dut.u_mode_ctrl.press_inc;
		"alarm": return u_dut.u_mode_ctrl.press_alarm;
		default: return 1'b0;
	endcase
endfunction

// Each level is held 4 to 6 sample periods
task automatic press_switch(input string name, input int count);
	int n;
	int hold;
	int waited;
	if (name != "mode" && name != "pos" && name != "inc" && name != "alarm") begin
		error_count = error_count + 1;
		$display("Unknown switch name %s in test data", name);
		return;
	end
	for (n = 0; n < count; n++) begin
		hold = 4 * SAMPLE_DIV + int'($urandom % (2 * SAMPLE_DIV + 1));
		set_switch(name, 1'b1);
		waited = 0;
		while (!press_seen(name) && waited < PRESS_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!press_seen(name)) begin
			timeout_count = timeout_count + 1;
			$display("Switch %s was pressed but no press pulse came", name);
		end else if (name == "mode") begin
			// CLOCK, SETUP, ALARM, then back to CLOCK
			exp_mode = (exp_mode == MODE_ALARM) ? MODE_CLOCK : exp_mode + 2'd1;
		end
		repeat (hold - waited) @(negedge clk);
		set_switch(name, 1'b0);
		hold = 4 * SAMPLE_DIV + int'($urandom % (2 * SAMPLE_DIV + 1));
		repeat (hold) @(negedge clk);
	end
endtask

task automatic bad_line(input string line);
	error_count = error_count + 1;
	$display("Malformed test data line: %s", line);
endtask

// --------------------------------------------------
// Main sequence
// --------------------------------------------------
initial begin
	int fd;
	string line;
	string cmd;
	string name;
	int a;
	int b;
	int c;
	int d;
	int fields;
	int unsigned seed_ret;

	seed_ret      = $urandom(32'hd84e_0e86);
	error_count   = 0;
	timeout_count = 0;
	assert_count  = 0;
	exp_mode      = MODE_CLOCK;
	got_frame     = '0;
	got_dp        = '0;
	rst_n         = 1'b0;
	sw_mode       = 1'b0;
	sw_pos        = 1'b0;
	sw_inc        = 1'b0;
	sw_alarm      = 1'b0;

	repeat (RESET_CYCLES) @(negedge clk);
	rst_n = 1'b1;
	@(negedge clk);

	// Scan starts on digit 0, which shows a zero
	check_enable(seg_enb, ~NUM_DIGITS'(1), "o_seg_enb");
	check_bit(alarm, 1'b0, "o_alarm");
	check_pattern(seg, digit_pattern(0), "o_seg");

	fd = $fopen("tb/clock_testdata.txt", "r");
	if (fd == 0) begin
		error_count = error_count + 1;
		$display("Could not open tb/clock_testdata.txt");
	end
	while (fd != 0 && !$feof(fd)) begin
		line = "";
		if ($fgets(line, fd) == 0) begin
			break;
		end
		if (line.len() < 2 || line[0] == "#") begin
			continue;
		end
		fields = $sscanf(line, "%s", cmd);
		case (cmd)
			"press": begin
				fields = $sscanf(line, "%s %s %d", cmd, name, a);
				if (fields == 3) begin
					press_switch(name, a);
				end else begin
					bad_line(line);
				end
			end
			"expect_frame": begin
				fields = $sscanf(line, "%s %d %d %d", cmd, a, b, c);
				if (fields == 4) begin
					expect_frame(a, b, c);
				end else begin
					bad_line(line);
				end
			end
			"wait_frame": begin
				fields = $sscanf(line, "%s %d %d %d %d", cmd, a, b, c, d);
				if (fields == 5) begin
					wait_frame(a, b, c, d);
				end else begin
					bad_line(line);
				end
			end
			"expect_alarm": begin
				fields = $sscanf(line, "%s %d %d", cmd, a, b);
				if (fields == 3) begin
					expect_alarm(a != 0, b);
				end else begin
					bad_line(line);
				end
			end
			default: bad_line(line);
		endcase
	end
	if (fd != 0) begin
		$fclose(fd);
	end

	@(negedge clk);
	assert_count = int'(u_dut.u_checker.fail_count);
	$display("Error counts: %0d mismatches, %0d timeouts, %0d assertion failures",
		error_count, timeout_count, assert_count);
	if (error_count == 0 && timeout_count == 0 && assert_count == 0) begin
		$display("*** PASSED ***");
	end else begin
		$display("*** FAILED ***");
	end
	$finish;
end

endmodule

`default_nettype wire

// File: tb/digital_clock_checker.sv
// --------------------------------------------------
// Concurrent assertions for the digital clock,
// bound into the top level: display enables, the
// alarm flag against alarm_en and the increment strobe
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module digital_clock_checker
	import clock_pkg::*;
(
	input	logic				clk,
	input	logic				rst_n,
	input	logic	[NUM_DIGITS-1:0]	i_seg_enb,
	input	logic				i_alarm,
	input	logic				i_alarm_en,
	input	logic				i_inc_pulse
);

int unsigned	fail_count = 0;

// Exactly one digit enabled, active low
a_enb_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~i_seg_enb))
	else begin
		fail_count = fail_count + 1;
		$error("o_seg_enb not one-hot low: %b", i_seg_enb);
	end

// Flag needs alarm_en in this cycle and the one before
a_alarm_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
		i_alarm |-> (i_alarm_en && $past(i_alarm_en)))
	else begin
		fail_count = fail_count + 1;
		$error("o_alarm high without alarm_en held since the previous cycle");
	end

// Increment strobe is a single clock wide
a_inc_single: assert property (@(posedge clk) disable iff (!rst_n) i_inc_pulse |=> !i_inc_pulse)
	else begin
		fail_count = fail_count + 1;
		$error("inc_pulse held for more than one cycle");
	end

endmodule

bind digital_clock_top digital_clock_checker u_checker (
	.clk		(clk),
	.rst_n		(rst_n),
	.i_seg_enb	(o_seg_enb),
	.i_alarm	(o_alarm),
	.i_alarm_en	(u_ctrl_if.alarm_en),
	.i_inc_pulse	(u_ctrl_if.inc_pulse)
);

`default_nettype wire

// File: hdl/digital_clock_top.sv
// --------------------------------------------------
// Digital clock top level
// Four switches in: mode, position, increment and
// alarm enable. Multiplexed display and alarm flag out
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module digital_clock_top
	import clock_pkg::*;
(
	input	logic				i_sw_mode,
	input	logic				i_sw_pos,
	input	logic				i_sw_inc,
	input	logic				i_sw_alarm,
	output	logic	[SEG_W-1:0]		o_seg,
	output	logic				o_seg_dp,
	output	logic	[NUM_DIGITS-1:0]	o_seg_enb,
	output	logic				o_alarm,
	input	logic				clk,
	input	logic				rst_n
);

clock_ctrl_if u_ctrl_if ();

logic	[FIELD_W-1:0]	time_sec;
logic	[FIELD_W-1:0]	time_min;
logic	[FIELD_W-1:0]	time_hour;
logic	[FIELD_W-1:0]	alarm_sec;
logic	[FIELD_W-1:0]	alarm_min;
logic	[FIELD_W-1:0]	alarm_hour;

mode_ctrl u_mode_ctrl (
	.i_sw_mode	(i_sw_mode),
	.i_sw_pos	(i_sw_pos),
	.i_sw_inc	(i_sw_inc),
	.i_sw_alarm	(i_sw_alarm),
	.ctrl		(u_ctrl_if.ctrl),
	.clk		(clk),
	.rst_n		(rst_n)
);

time_keeper u_time_keeper (
	.ctrl		(u_ctrl_if.time_keeper),
	.o_sec		(time_sec),
	.o_min		(time_min),
	.o_hour		(time_hour),
	.clk		(clk),
	.rst_n		(rst_n)
);

alarm_keeper u_alarm_keeper (
	.ctrl		(u_ctrl_if.alarm_keeper),
	.i_sec		(time_sec),
	.i_min		(time_min),
	.i_hour		(time_hour),
	.o_alarm_sec	(alarm_sec),
	.o_alarm_min	(alarm_min),
	.o_alarm_hour	(alarm_hour),
	.o_alarm	(o_alarm),
	.clk		(clk),
	.rst_n		(rst_n)
);

seg_display u_seg_display (
	.i_mode		(u_ctrl_if.mode),
	.i_sec		(time_sec),
	.i_min		(time_min),
	.i_hour		(time_hour),
	.i_alarm_sec	(alarm_sec),
	.i_alarm_min	(alarm_min),
	.i_alarm_hour	(alarm_hour),
	.o_seg		(o_seg),
	.o_seg_dp	(o_seg_dp),
	.o_seg_enb	(o_seg_enb),
	.clk		(clk),
	.rst_n		(rst_n)
);

endmodule

`default_nettype wire

// File: hdl/seg_display.sv
// --------------------------------------------------
// Six-digit seven-segment display driver
// Shows the alarm time in ALARM mode and the clock
// otherwise; scans one digit at a time with active
// low enables and mode bits on the decimal points
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module seg_display
	import clock_pkg::*;
(
	input	logic	[MODE_W-1:0]		i_mode,
	input	logic	[FIELD_W-1:0]		i_sec,
	input	logic	[FIELD_W-1:0]		i_min,
	input	logic	[FIELD_W-1:0]		i_hour,
	input	logic	[FIELD_W-1:0]		i_alarm_sec,
	input	logic	[FIELD_W-1:0]		i_alarm_min,
	input	logic	[FIELD_W-1:0]		i_alarm_hour,
	output	logic	[SEG_W-1:0]		o_seg,
	output	logic				o_seg_dp,
	output	logic	[NUM_DIGITS-1:0]	o_seg_enb,
	input	logic				clk,
	input	logic				rst_n
);

logic				show_alarm;
logic	[FIELD_W-1:0]		show_sec;
logic	[FIELD_W-1:0]		show_min;
logic	[FIELD_W-1:0]		show_hour;
hms_seg_u			frame;
logic	[NUM_DIGITS-1:0]	dp_vec;
logic	[SCAN_CNT_W-1:0]	scan_cnt;
logic	[DIGIT_SEL_W-1:0]	digit_sel;

// Tens pattern in the upper half, ones in the lower
function automatic logic [2*SEG_W-1:0] seg_pair(input logic [FIELD_W-1:0] field);
	logic [DIGIT_W-1:0] tens;
	logic [DIGIT_W-1:0] ones;
	tens = DIGIT_W'(field / FIELD_W'(10));
	ones = DIGIT_W'(field % FIELD_W'(10));
	return {seg_decode(tens), seg_decode(ones)};
endfunction

// --------------------------------------------------
// Frame build
// --------------------------------------------------
assign show_alarm = (i_mode == MODE_ALARM);
assign show_sec   = show_alarm ? i_alarm_sec : i_sec;
assign show_min   = show_alarm ? i_alarm_min : i_min;
assign show_hour  = show_alarm ? i_alarm_hour : i_hour;

always_comb begin
	frame.pair.sec  = seg_pair(show_sec);
	frame.pair.min  = seg_pair(show_min);
	frame.pair.hour = seg_pair(show_hour);
end

// Mode bit 0 on digit 0, bit 1 on digit 1
assign dp_vec = NUM_DIGITS'(i_mode);

// --------------------------------------------------
// Digit scan
// --------------------------------------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (rst_n == 1'b0) begin
		scan_cnt  <= '0;
		digit_sel <= '0;
	end else if (scan_cnt == SCAN_CNT_W'(SCAN_DIV - 1)) begin
		scan_cnt  <= '0;
		if (digit_sel == DIGIT_SEL_W'(NUM_DIGITS - 1)) begin
			digit_sel <= '0;
		end else begin
			digit_sel <= digit_sel + 1'b1;
		end
	end else begin
		scan_cnt <= scan_cnt + 1'b1;
	end
end

assign o_seg_enb = ~(NUM_DIGITS'(1) << digit_sel);
assign o_seg     = frame.digit[digit_sel];
assign o_seg_dp  = dp_vec[digit_sel];

endmodule

`default_nettype wire

// File: hdl/alarm_keeper.sv
// --------------------------------------------------
// Alarm setting and alarm flag
// Holds the alarm time, set field by field in ALARM
// mode, and raises o_alarm when the time matches it
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module alarm_keeper
	import clock_pkg::*;
(
	clock_ctrl_if.alarm_keeper	ctrl,
	input	logic	[FIELD_W-1:0]	i_sec,
	input	logic	[FIELD_W-1:0]	i_min,
	input	logic	[FIELD_W-1:0]	i_hour,
	output	logic	[FIELD_W-1:0]	o_alarm_sec,
	output	logic	[FIELD_W-1:0]	o_alarm_min,
	output	logic	[FIELD_W-1:0]	o_alarm_hour,
	output	logic			o_alarm,
	input	logic			clk,
	input	logic			rst_n
);

logic		time_match;
logic		alarm_hit;

// --------------------------------------------------
// Alarm time
// --------------------------------------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (rst_n == 1'b0) begin
		o_alarm_sec  <= '0;
		o_alarm_min  <= '0;
		o_alarm_hour <= '0;
	end else if ((ctrl.mode == MODE_ALARM) && ctrl.inc_pulse) begin
		case (ctrl.position)
			POS_SEC:  o_alarm_sec  <= field_inc(o_alarm_sec, SEC_MAX);
			POS_MIN:  o_alarm_min  <= field_inc(o_alarm_min, MIN_MAX);
			POS_HOUR: o_alarm_hour <= field_inc(o_alarm_hour, HOUR_MAX);
			default:  ;
		endcase
	end
end

// --------------------------------------------------
// Match and flag
// --------------------------------------------------
assign time_match = (i_sec == o_alarm_sec) &&
		    (i_min == o_alarm_min) &&
		    (i_hour == o_alarm_hour);

// Latches on a match, held until the alarm is switched off
always_ff @(posedge clk or negedge rst_n) begin
	if (rst_n == 1'b0) begin
		alarm_hit <= 1'b0;
	end else if (!ctrl.alarm_en) begin
		alarm_hit <= 1'b0;
	end else if (time_match) begin
		alarm_hit <= 1'b1;
	end
end

// Drops in the same cycle as alarm_en
assign o_alarm = alarm_hit & ctrl.alarm_en;

endmodule

`default_nettype wire

// File: hdl/time_keeper.sv
// --------------------------------------------------
// Running time of day
// Counts seconds with carries into minutes and hours;
// in SETUP the selected field is stepped instead
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module time_keeper
	import clock_pkg::*;
(
	clock_ctrl_if.time_keeper	ctrl,
	output	logic	[FIELD_W-1:0]	o_sec,
	output	logic	[FIELD_W-1:0]	o_min,
	output	logic	[FIELD_W-1:0]	o_hour,
	input	logic			clk,
	input	logic			rst_n
);

always_ff @(posedge clk or negedge rst_n) begin
	if (rst_n == 1'b0) begin
		o_sec  <= '0;
		o_min  <= '0;
		o_hour <= '0;
	end else if (ctrl.mode == MODE_SETUP) begin
		// Time stands still while it is being set
		if (ctrl.inc_pulse) begin
			case (ctrl.position)
				POS_SEC:  o_sec  <= field_inc(o_sec, SEC_MAX);
				POS_MIN:  o_min  <= field_inc(o_min, MIN_MAX);
				POS_HOUR: o_hour <= field_inc(o_hour, HOUR_MAX);
				default:  ;
			endcase
		end
	end else if (ctrl.sec_tick) begin
		o_sec <= field_inc(o_sec, SEC_MAX);
		if (o_sec >= SEC_MAX) begin
			o_min <= field_inc(o_min, MIN_MAX);
			// Hour carry only at xx:59:59
			if (o_min >= MIN_MAX) begin
				o_hour <= field_inc(o_hour, HOUR_MAX);
			end
		end
	end
end

endmodule

`default_nettype wire

// File: hdl/mode_ctrl.sv
// --------------------------------------------------
// Clock controller
// Makes the second tick and the switch sample strobe,
// debounces the four switches and keeps the mode,
// edit position and alarm enable
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module mode_ctrl
	import clock_pkg::*;
(
	input	logic		i_sw_mode,
	input	logic		i_sw_pos,
	input	logic		i_sw_inc,
	input	logic		i_sw_alarm,
	clock_ctrl_if.ctrl	ctrl,
	input	logic		clk,
	input	logic		rst_n
);

logic	[SEC_CNT_W-1:0]		sec_cnt;
logic	[SAMPLE_CNT_W-1:0]	sample_cnt;
logic				sample_stb;

logic				press_mode;
logic				press_pos;
logic				press_inc;
logic				press_alarm;

// --------------------------------------------------
// Dividers
// --------------------------------------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (rst_n == 1'b0) begin
		sec_cnt       <= '0;
		ctrl.sec_tick <= 1'b0;
	end else if (sec_cnt == SEC_CNT_W'(SEC_DIV - 1)) begin
		sec_cnt       <= '0;
		ctrl.sec_tick <= 1'b1;
	end else begin
		sec_cnt       <= sec_cnt + 1'b1;
		ctrl.sec_tick <= 1'b0;
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (rst_n == 1'b0) begin
		sample_cnt <= '0;
		sample_stb <= 1'b0;
	end else begin
		sample_stb <= (sample_cnt == SAMPLE_CNT_W'(SAMPLE_DIV - 1));
		if (sample_cnt == SAMPLE_CNT_W'(SAMPLE_DIV - 1)) begin
			sample_cnt <= '0;
		end else begin
			sample_cnt <= sample_cnt + 1'b1;
		end
	end
end

// --------------------------------------------------
// Switches
// --------------------------------------------------
switch_debounce u_db_mode (
	.i_sw		(i_sw_mode),
	.i_sample	(sample_stb),
	.o_press	(press_mode),
	.clk		(clk),
	.rst_n		(rst_n)
);

switch_debounce u_db_pos (
	.i_sw		(i_sw_pos),
	.i_sample	(sample_stb),
	.o_press	(press_pos),
	.clk		(clk),
	.rst_n		(rst_n)
);

switch_debounce u_db_inc (
	.i_sw		(i_sw_inc),
	.i_sample	(sample_stb),
	.o_press	(press_inc),
	.clk		(clk),
	.rst_n		(rst_n)
);

switch_debounce u_db_alarm (
	.i_sw		(i_sw_alarm),
	.i_sample	(sample_stb),
	.o_press	(press_alarm),
	.clk		(clk),
	.rst_n		(rst_n)
);

// --------------------------------------------------
// Mode, position and alarm enable
// --------------------------------------------------
always_ff @(posedge clk or negedge rst_n) begin
	if (rst_n == 1'b0) begin
		ctrl.mode     <= MODE_CLOCK;
		ctrl.position <= POS_SEC;
		ctrl.alarm_en <= 1'b0;
	end else begin
		if (press_mode) begin
			ctrl.mode <= (ctrl.mode >= MODE_ALARM) ? MODE_CLOCK : ctrl.mode + 1'b1;
		end
		if (press_pos) begin
			ctrl.position <= (ctrl.position >= POS_HOUR) ? POS_SEC : ctrl.position + 1'b1;
		end
		if (press_alarm) begin
			ctrl.alarm_en <= ~ctrl.alarm_en;
		end
	end
end

// Keepers decide by mode whether the press counts
assign ctrl.inc_pulse = press_inc;

endmodule

`default_nettype wire

// File: hdl/switch_debounce.sv
// --------------------------------------------------
// Switch debouncer
// Samples the switch level on each sample strobe and
// gives a one-cycle press pulse on a low to high step
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module switch_debounce
	import clock_pkg::*;
(
	input	logic	i_sw,
	input	logic	i_sample,
	output	logic	o_press,
	input	logic	clk,
	input	logic	rst_n
);

logic		sw_cur;
logic		sw_prev;
logic		sample_d;

// Bounce shorter than one sample period is never seen
always_ff @(posedge clk or negedge rst_n) begin
	if (rst_n == 1'b0) begin
		sw_cur   <= 1'b0;
		sw_prev  <= 1'b0;
		sample_d <= 1'b0;
	end else begin
		sample_d <= i_sample;
		if (i_sample) begin
			sw_cur  <= i_sw;
			sw_prev <= sw_cur;
		end
	end
end

// Only valid on the cycle right after a sample
assign o_press = sample_d & sw_cur & ~sw_prev;

endmodule

`default_nettype wire

// File: hdl/clock_ctrl_if.sv
// --------------------------------------------------
// Control bundle from mode_ctrl to the time and
// alarm keepers: mode, position and one-cycle strobes
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface clock_ctrl_if
	import clock_pkg::*;
();

logic	[MODE_W-1:0]	mode;
logic	[POS_W-1:0]	position;
logic			inc_pulse;
logic			sec_tick;
logic			alarm_en;

modport ctrl (output mode, position, inc_pulse, sec_tick, alarm_en);

modport time_keeper (input mode, position, inc_pulse, sec_tick);

modport alarm_keeper (input mode, position, inc_pulse, alarm_en);

endinterface

`default_nettype wire

// File: hdl/clock_pkg.sv
// --------------------------------------------------
// Shared definitions for the digital clock
// Field widths and limits, mode and position codes,
// clock dividers and the six-digit display word.
// Divider values suit simulation; edit them here for a board
// --------------------------------------------------
`default_nettype none

package clock_pkg;

// Widths
localparam int FIELD_W    = 6;
localparam int DIGIT_W    = 4;
localparam int SEG_W      = 7;
localparam int NUM_DIGITS = 6;
localparam int MODE_W     = 2;
localparam int POS_W      = 2;

// Field limits
localparam logic [FIELD_W-1:0] SEC_MAX  = 59;
localparam logic [FIELD_W-1:0] MIN_MAX  = 59;
localparam logic [FIELD_W-1:0] HOUR_MAX = 23;

// Mode cycles CLOCK, SETUP, ALARM
localparam logic [MODE_W-1:0] MODE_CLOCK = 2'd0;
localparam logic [MODE_W-1:0] MODE_SETUP = 2'd1;
localparam logic [MODE_W-1:0] MODE_ALARM = 2'd2;

localparam logic [POS_W-1:0] POS_SEC  = 2'd0;
localparam logic [POS_W-1:0] POS_MIN  = 2'd1;
localparam logic [POS_W-1:0] POS_HOUR = 2'd2;

// Clocks per event
localparam int SEC_DIV    = 2000;
localparam int SAMPLE_DIV = 8;
localparam int SCAN_DIV   = 16;

localparam int SEC_CNT_W    = $clog2(SEC_DIV);
localparam int SAMPLE_CNT_W = $clog2(SAMPLE_DIV);
localparam int SCAN_CNT_W   = $clog2(SCAN_DIV);
localparam int DIGIT_SEL_W  = $clog2(NUM_DIGITS);

// Digit 0 is the seconds ones digit, digit 5 the hours tens digit
typedef union packed {
	logic [NUM_DIGITS-1:0][SEG_W-1:0] digit;
	struct packed {
		logic [2*SEG_W-1:0] hour;
		logic [2*SEG_W-1:0] min;
		logic [2*SEG_W-1:0] sec;
	} pair;
} hms_seg_u;

// Segments a..g, a in the MSB, active high
function automatic logic [SEG_W-1:0] seg_decode(input logic [DIGIT_W-1:0] num);
	case (num)
		4'd0:    return 7'b111_1110;
		4'd1:    return 7'b011_0000;
		4'd2:    return 7'b110_1101;
		4'd3:    return 7'b111_1001;
		4'd4:    return 7'b011_0011;
		4'd5:    return 7'b101_1011;
		4'd6:    return 7'b101_1111;
		4'd7:    return 7'b111_0000;
		4'd8:    return 7'b111_1111;
		4'd9:    return 7'b111_0011;
		default: return 7'b000_0000;
	endcase
endfunction

// Increment with wrap to 0 past the limit, no carry out
function automatic logic [FIELD_W-1:0] field_inc(
	input logic [FIELD_W-1:0] value,
	input logic [FIELD_W-1:0] limit
);
	return (value >= limit) ? '0 : value + 1'b1;
endfunction

endpackage

`default_nettype wire
